/* global_buffer_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, address fields and chain packet types for
// the global buffer tile chain.
// imported by every rtl module and by the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package global_buffer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processor side widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one bank word.
    localparam int BANK_DATA_WIDTH = 64;
    // one strobe bit per byte lane.
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    // byte address from the processor.
    localparam int GLB_ADDR_WIDTH = 16;
    // address bits below the word index.
    localparam int BANK_BYTE_OFFSET = 3;
    // tile select, sits right above the bank word index.
    localparam int TILE_SEL_WIDTH = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CFG_DATA_WIDTH = 32;
    localparam int CFG_ADDR_WIDTH = 8;
    // upper nibble is the tile id.
    localparam int CFG_TILE_ID_WIDTH = 4;
    // lower nibble is the register index.
    localparam int CFG_REG_IDX_WIDTH = 4;

    // register map inside each tile.
    localparam logic [CFG_REG_IDX_WIDTH-1:0] CFG_REG_WPROT = 4'd0;
    localparam logic [CFG_REG_IDX_WIDTH-1:0] CFG_REG_SCRATCH = 4'd1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // chain packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte strobed write request.
    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // read request.
    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // read response, filled in by the owning tile.
    typedef struct packed {
        logic                       rd_data_valid;
        logic [BANK_DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // one chain word, used east and west bound.
    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

    // config request and response in one word.
    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_data_valid;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
    } cfg_packet_t;

endpackage

/* glb_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single port word memory of one tile.
// byte strobed writes, one cycle registered read.
// a read on the same cycle as a write sees the old word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_bank #(
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic                                         clk,

    // write port
    input  logic                                         wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [BANK_ADDR_WIDTH-1:0]                   wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] wr_data,

    // read port
    input  logic                                         rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0]                   rd_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import global_buffer_pkg::*;

    localparam int NUM_WORDS = 2 ** BANK_ADDR_WIDTH;
    localparam int BYTE_WIDTH = BANK_DATA_WIDTH / BANK_STRB_WIDTH;

    // stored as byte lanes so each strobe maps to one lane.
    logic [BANK_STRB_WIDTH-1:0][BYTE_WIDTH-1:0] mem [NUM_WORDS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write, lane by lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                // untouched lanes keep their bytes.
                if (wr_strb[b]) begin
                    mem[wr_addr][b] <= wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // registered read.
    // holds its last word while rd_en is low.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* glb_start.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// west end of the tile chain.
// packs processor and config requests into chain packets
// and registers the responses coming back from tile 0.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_start (
    input  logic                                         clk,
    input  logic                                         rst,

    // processor requests
    input  logic                                         proc_wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                         proc_rd_en,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic                                         proc_rd_data_valid,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,

    // config bus
    input  global_buffer_pkg::cfg_packet_t                cfg_req,
    output global_buffer_pkg::cfg_packet_t                cfg_rsp,

    // chain side
    output global_buffer_pkg::packet_t                    proc_packet_esto,
    input  global_buffer_pkg::packet_t                    proc_packet_wsti,
    output global_buffer_pkg::cfg_packet_t                cfg_esto,
    input  global_buffer_pkg::cfg_packet_t                cfg_wsti
);
    import global_buffer_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // east bound request stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response fields start out empty.
    always_ff @(posedge clk) begin
        if (rst) begin
            proc_packet_esto <= '0;
            cfg_esto <= '0;
        end else begin
            proc_packet_esto.wr <= '{wr_en: proc_wr_en, wr_strb: proc_wr_strb,
                                     wr_addr: proc_wr_addr, wr_data: proc_wr_data};
            proc_packet_esto.rdrq <= '{rd_en: proc_rd_en, rd_addr: proc_rd_addr};
            proc_packet_esto.rdrs <= '0;
            cfg_esto <= '{wr_en: cfg_req.wr_en, rd_en: cfg_req.rd_en,
                          addr: cfg_req.addr, wr_data: cfg_req.wr_data,
                          rd_data_valid: 1'b0, rd_data: '0};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processor facing response stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // only the response part comes back west.
    always_ff @(posedge clk) begin
        if (rst) begin
            proc_rd_data_valid <= 1'b0;
            proc_rd_data <= '0;
            cfg_rsp <= '0;
        end else begin
            proc_rd_data_valid <= proc_packet_wsti.rdrs.rd_data_valid;
            proc_rd_data <= proc_packet_wsti.rdrs.rd_data;
            cfg_rsp <= '{wr_en: 1'b0, rd_en: 1'b0, addr: '0, wr_data: '0,
                         rd_data_valid: cfg_wsti.rd_data_valid,
                         rd_data: cfg_wsti.rd_data};
        end
    end

endmodule

/* glb_tile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one global buffer tile with its bank and config registers.
// east stage carries requests, west stage carries responses.
// the tile built with LAST turns east traffic back west.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module glb_tile #(
    parameter int TILE_ID = 0,
    parameter int BANK_ADDR_WIDTH = 8,
    parameter bit LAST = 1'b0
) (
    input  logic                           clk,
    input  logic                           rst,

    // processor chain
    input  global_buffer_pkg::packet_t     proc_packet_esti,
    output global_buffer_pkg::packet_t     proc_packet_esto,
    input  global_buffer_pkg::packet_t     proc_packet_wsti,
    output global_buffer_pkg::packet_t     proc_packet_wsto,

    // config chain
    input  global_buffer_pkg::cfg_packet_t cfg_esti,
    output global_buffer_pkg::cfg_packet_t cfg_esto,
    input  global_buffer_pkg::cfg_packet_t cfg_wsti,
    output global_buffer_pkg::cfg_packet_t cfg_wsto
);
    import global_buffer_pkg::*;

    // tile select sits above the word index.
    localparam int TILE_SEL_LSB = BANK_BYTE_OFFSET + BANK_ADDR_WIDTH;
    localparam logic [TILE_SEL_WIDTH-1:0] TILE_SEL = TILE_SEL_WIDTH'(TILE_ID);
    localparam logic [CFG_TILE_ID_WIDTH-1:0] CFG_TILE = CFG_TILE_ID_WIDTH'(TILE_ID);

    logic                         wr_hit;
    logic                         rd_hit;
    logic [BANK_DATA_WIDTH-1:0]   bank_rd_data;
    packet_t                      esto_q;
    logic                         rd_hit_q;
    logic                         rd_fill_q;
    logic                         wprot;
    logic [CFG_DATA_WIDTH-1:0]    scratch;
    logic                         cfg_hit;
    logic [CFG_REG_IDX_WIDTH-1:0] cfg_idx;
    cfg_packet_t                  cfg_nxt;
    packet_t                      proc_west_src;
    cfg_packet_t                  cfg_west_src;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode and bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_hit = proc_packet_esti.wr.wr_en
                 && (proc_packet_esti.wr.wr_addr[TILE_SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);
    assign rd_hit = proc_packet_esti.rdrq.rd_en
                 && (proc_packet_esti.rdrq.rd_addr[TILE_SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);

    // write protect drops processor writes only.
    glb_bank #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) u_bank (
        .clk     (clk),
        .wr_en   (wr_hit && !wprot),
        .wr_strb (proc_packet_esti.wr.wr_strb),
        .wr_addr (proc_packet_esti.wr.wr_addr[BANK_BYTE_OFFSET +: BANK_ADDR_WIDTH]),
        .wr_data (proc_packet_esti.wr.wr_data),
        .rd_en   (rd_hit),
        .rd_addr (proc_packet_esti.rdrq.rd_addr[BANK_BYTE_OFFSET +: BANK_ADDR_WIDTH]),
        .rd_data (bank_rd_data)
    );

    // east stage.
    // the bank output register lines up with this one.
    always_ff @(posedge clk) begin
        if (rst) begin
            esto_q <= '0;
            rd_hit_q <= 1'b0;
            rd_fill_q <= 1'b0;
        end else begin
            esto_q <= proc_packet_esti;
            rd_hit_q <= rd_hit;
            // end of chain, nobody owned this read.
            rd_fill_q <= LAST && proc_packet_esti.rdrq.rd_en && !rd_hit
                      && !proc_packet_esti.rdrs.rd_data_valid;
        end
    end

    always_comb begin
        proc_packet_esto = esto_q;
        if (rd_hit_q) begin
            proc_packet_esto.rdrs.rd_data_valid = 1'b1;
            proc_packet_esto.rdrs.rd_data = bank_rd_data;
        end else if (rd_fill_q) begin
            proc_packet_esto.rdrs.rd_data_valid = 1'b1;
            proc_packet_esto.rdrs.rd_data = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // config registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cfg_idx = cfg_esti.addr[CFG_REG_IDX_WIDTH-1:0];
    assign cfg_hit = (cfg_esti.addr[CFG_ADDR_WIDTH-1 -: CFG_TILE_ID_WIDTH] == CFG_TILE);

    always_ff @(posedge clk) begin
        if (rst) begin
            wprot <= 1'b0;
            scratch <= '0;
        end else if (cfg_esti.wr_en && cfg_hit) begin
            case (cfg_idx)
                CFG_REG_WPROT:   wprot <= cfg_esti.wr_data[0];
                CFG_REG_SCRATCH: scratch <= cfg_esti.wr_data;
                default:         ;
            endcase
        end
    end

    // read data joins the packet on its way east.
    // unknown index reads as zero.
    always_comb begin
        cfg_nxt = cfg_esti;
        if (cfg_esti.rd_en && cfg_hit) begin
            cfg_nxt.rd_data_valid = 1'b1;
            case (cfg_idx)
                CFG_REG_WPROT:   cfg_nxt.rd_data = CFG_DATA_WIDTH'(wprot);
                CFG_REG_SCRATCH: cfg_nxt.rd_data = scratch;
                default:         cfg_nxt.rd_data = '0;
            endcase
        end else if (LAST && cfg_esti.rd_en && !cfg_esti.rd_data_valid) begin
            cfg_nxt.rd_data_valid = 1'b1;
            cfg_nxt.rd_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_esto <= '0;
        end else begin
            cfg_esto <= cfg_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // west stage, responses only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // last tile feeds its own east output back.
    always_comb begin
        proc_west_src = '0;
        cfg_west_src = '0;
        if (LAST) begin
            proc_west_src.rdrs = proc_packet_esto.rdrs;
            cfg_west_src.rd_data_valid = cfg_esto.rd_data_valid;
            cfg_west_src.rd_data = cfg_esto.rd_data;
        end else begin
            proc_west_src.rdrs = proc_packet_wsti.rdrs;
            cfg_west_src.rd_data_valid = cfg_wsti.rd_data_valid;
            cfg_west_src.rd_data = cfg_wsti.rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            proc_packet_wsto <= '0;
            cfg_wsto <= '0;
        end else begin
            proc_packet_wsto <= proc_west_src;
            cfg_wsto <= cfg_west_src;
        end
    end

endmodule

/* global_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// global buffer top level.
// start block on the west end, then NUM_TILES tiles east.
// read latency is 2*NUM_TILES+2 cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module global_buffer #(
    parameter int NUM_TILES = 4,
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic                                         clk,
    input  logic                                         rst,

    // processor side
    input  logic                                         proc_wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                         proc_rd_en,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic                                         proc_rd_data_valid,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,

    // config side
    input  global_buffer_pkg::cfg_packet_t                cfg_req,
    output global_buffer_pkg::cfg_packet_t                cfg_rsp
);
    import global_buffer_pkg::*;

    // index k is the input of tile k.
    packet_t     proc_east [NUM_TILES+1];
    packet_t     proc_west [NUM_TILES+1];
    cfg_packet_t cfg_east [NUM_TILES+1];
    cfg_packet_t cfg_west [NUM_TILES+1];

    // nothing lies east of the last tile.
    assign proc_west[NUM_TILES] = '0;
    assign cfg_west[NUM_TILES] = '0;

    glb_start u_start (
        .clk                (clk),
        .rst                (rst),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data_valid (proc_rd_data_valid),
        .proc_rd_data       (proc_rd_data),
        .cfg_req            (cfg_req),
        .cfg_rsp            (cfg_rsp),
        .proc_packet_esto   (proc_east[0]),
        .proc_packet_wsti   (proc_west[0]),
        .cfg_esto           (cfg_east[0]),
        .cfg_wsti           (cfg_west[0])
    );

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID         (k),
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
            .LAST            (k == NUM_TILES - 1)
        ) u_tile (
            .clk              (clk),
            .rst              (rst),
            .proc_packet_esti (proc_east[k]),
            .proc_packet_esto (proc_east[k+1]),
            .proc_packet_wsti (proc_west[k+1]),
            .proc_packet_wsto (proc_west[k]),
            .cfg_esti         (cfg_east[k]),
            .cfg_esto         (cfg_east[k+1]),
            .cfg_wsti         (cfg_west[k+1]),
            .cfg_wsto         (cfg_west[k])
        );
    end

endmodule

/* tb_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock and reset source for the global buffer testbench.
// reset is released 1 ns after the last reset edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // free running clock.
    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // synchronous reset, held for a few edges.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* tb_global_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the global buffer tile chain.
// drives processor and config requests, keeps a byte level
// reference of every tile and checks data and latency of
// each response in issue order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_global_buffer;
    import global_buffer_pkg::*;

    localparam int NUM_TILES = 4;
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int CLK_PERIOD = 4;
    localparam int LATENCY = 2 * NUM_TILES + 2;
    // words per tile that the tests touch.
    localparam int WORDS = 16;
    localparam int N_PARTIAL = 48;
    localparam int N_BURST = 96;
    localparam int N_WPROT = 32;
    localparam int WP_TILE = 2;
    localparam int TOTAL_REQS = 5 + 2 * NUM_TILES * WORDS + 2 * N_PARTIAL + N_BURST
                              + 3 + 4 * N_WPROT + 3 * NUM_TILES + 2 + 6 * (LATENCY + 1);
    localparam int WATCHDOG_NS = (TOTAL_REQS + 200) * CLK_PERIOD;

    // one expected response with its issue cycle.
    typedef struct packed {
        logic [63:0] data;
        logic [31:0] cycle;
    } expect_t;

    logic                       clk;
    logic                       rst;
    logic                       proc_wr_en;
    logic [BANK_STRB_WIDTH-1:0] proc_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]  proc_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_wr_data;
    logic                       proc_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]  proc_rd_addr;
    logic                       proc_rd_data_valid;
    logic [BANK_DATA_WIDTH-1:0] proc_rd_data;
    cfg_packet_t                cfg_req;
    cfg_packet_t                cfg_rsp;

    // reference model.
    logic [7:0]  ref_mem [NUM_TILES][WORDS][BANK_STRB_WIDTH];
    logic        ref_wprot [NUM_TILES];
    logic [31:0] ref_scratch [NUM_TILES];

    expect_t     rd_q [$];
    expect_t     cfg_q [$];
    logic [31:0] cycle;
    integer      seed = 32'h84e2_c07d;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    global_buffer #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) UUT (
        .clk                (clk),
        .rst                (rst),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data_valid (proc_rd_data_valid),
        .proc_rd_data       (proc_rd_data),
        .cfg_req            (cfg_req),
        .cfg_rsp            (cfg_rsp)
    );

    // cycle count for latency.
    initial cycle = 0;
    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t signal=%s got=%h expected=%h",
                                $time, name, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte address of a tile word.
    function automatic logic [GLB_ADDR_WIDTH-1:0] make_addr(input int tile, input int word);
        logic [GLB_ADDR_WIDTH-1:0] a;
        a = '0;
        a[BANK_BYTE_OFFSET +: BANK_ADDR_WIDTH] = BANK_ADDR_WIDTH'(word);
        a[BANK_BYTE_OFFSET + BANK_ADDR_WIDTH +: TILE_SEL_WIDTH] = TILE_SEL_WIDTH'(tile);
        return a;
    endfunction

    // fill pattern built from the whole address.
    function automatic logic [63:0] fill_word(input logic [GLB_ADDR_WIDTH-1:0] a);
        return {a, ~a, a ^ 16'ha5c3, a + 16'h3c71};
    endfunction

    // unowned tile select reads as zero.
    function automatic logic [63:0] ref_read(input int tile, input int word);
        logic [63:0] w;
        w = '0;
        if (tile < NUM_TILES) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                w[b*8 +: 8] = ref_mem[tile][word][b];
            end
        end
        return w;
    endfunction

    // unknown index or tile reads as zero.
    function automatic logic [31:0] ref_cfg_read(input int tile, input int idx);
        logic [31:0] v;
        v = '0;
        if (tile < NUM_TILES && idx == int'(CFG_REG_WPROT)) begin
            v = 32'(ref_wprot[tile]);
        end else if (tile < NUM_TILES && idx == int'(CFG_REG_SCRATCH)) begin
            v = ref_scratch[tile];
        end
        return v;
    endfunction

    // protected tiles drop writes.
    task automatic ref_write(input int tile, input int word,
                             input logic [BANK_STRB_WIDTH-1:0] strb, input logic [63:0] data);
        if (tile < NUM_TILES && !ref_wprot[tile]) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    ref_mem[tile][word][b] = data[b*8 +: 8];
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // moves to the next drive point with the strobes idle.
    task automatic tick();
        @(posedge clk);
        #1;
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_req.wr_en = 1'b0;
        cfg_req.rd_en = 1'b0;
    endtask

    // call before set_write in the same cycle.
    task automatic set_read(input int tile, input int word);
        expect_t e;
        e.data = ref_read(tile, word);
        e.cycle = cycle;
        rd_q.push_back(e);
        proc_rd_en = 1'b1;
        proc_rd_addr = make_addr(tile, word);
    endtask

    task automatic set_write(input int tile, input int word,
                             input logic [BANK_STRB_WIDTH-1:0] strb, input logic [63:0] data);
        proc_wr_en = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = make_addr(tile, word);
        proc_wr_data = data;
        ref_write(tile, word, strb, data);
    endtask

    task automatic cfg_write(input int tile, input int idx, input logic [31:0] data);
        cfg_req.wr_en = 1'b1;
        cfg_req.addr = {CFG_TILE_ID_WIDTH'(tile), CFG_REG_IDX_WIDTH'(idx)};
        cfg_req.wr_data = data;
        if (tile < NUM_TILES && idx == int'(CFG_REG_WPROT)) begin
            ref_wprot[tile] = data[0];
        end else if (tile < NUM_TILES && idx == int'(CFG_REG_SCRATCH)) begin
            ref_scratch[tile] = data;
        end
        tick();
    endtask

    task automatic cfg_read(input int tile, input int idx);
        expect_t e;
        e.data = 64'(ref_cfg_read(tile, idx));
        e.cycle = cycle;
        cfg_q.push_back(e);
        cfg_req.rd_en = 1'b1;
        cfg_req.addr = {CFG_TILE_ID_WIDTH'(tile), CFG_REG_IDX_WIDTH'(idx)};
        tick();
    endtask

    // the last response is due LATENCY cycles after its request.
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((rd_q.size() != 0 || cfg_q.size() != 0) && waited <= LATENCY) begin
            tick();
            waited++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequences
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // no response may show up before any read.
    task automatic run_idle_check();
        repeat (5) begin
            check_value("proc_rd_data_valid", 64'(proc_rd_data_valid), 64'd0);
            check_value("cfg_rsp.rd_data_valid", 64'(cfg_rsp.rd_data_valid), 64'd0);
            tick();
        end
    endtask

    // fills every used word and then reads all back.
    task automatic run_full_writes();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int w = 0; w < WORDS; w++) begin
                set_write(t, w, '1, fill_word(make_addr(t, w)));
                tick();
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int w = 0; w < WORDS; w++) begin
                set_read(t, w);
                tick();
            end
        end
        wait_drain();
    endtask

    task automatic run_partial_strobes();
        int tile;
        int word;
        for (int i = 0; i < N_PARTIAL; i++) begin
            tile = $unsigned($random(seed)) % NUM_TILES;
            word = $random(seed) & (WORDS - 1);
            set_write(tile, word, BANK_STRB_WIDTH'($random(seed)),
                      {$random(seed), $random(seed)});
            tick();
            set_read(tile, word);
            tick();
        end
        wait_drain();
    endtask

    // a read every cycle with some beyond the last tile.
    task automatic run_read_burst();
        int rd_tile;
        int wr_tile;
        for (int i = 0; i < N_BURST; i++) begin
            if ($random(seed) & 1) begin
                rd_tile = $unsigned($random(seed)) % NUM_TILES;
            end else begin
                rd_tile = $random(seed) & 15;
            end
            set_read(rd_tile, $random(seed) & (WORDS - 1));
            if ($random(seed) & 1) begin
                wr_tile = $unsigned($random(seed)) % NUM_TILES;
                set_write(wr_tile, $random(seed) & (WORDS - 1),
                          BANK_STRB_WIDTH'($random(seed)), {$random(seed), $random(seed)});
            end
            tick();
        end
        wait_drain();
    endtask

    task automatic run_write_protect();
        int word;
        cfg_write(WP_TILE, int'(CFG_REG_WPROT), 32'd1);
        cfg_read(WP_TILE, int'(CFG_REG_WPROT));
        // every tile is written and the protected one keeps its data.
        for (int i = 0; i < N_WPROT; i++) begin
            word = $random(seed) & (WORDS - 1);
            set_write(i % NUM_TILES, word, '1, {$random(seed), $random(seed)});
            tick();
            set_read(i % NUM_TILES, word);
            tick();
        end
        cfg_write(WP_TILE, int'(CFG_REG_WPROT), 32'd0);
        for (int i = 0; i < N_WPROT; i++) begin
            set_write(WP_TILE, i % WORDS, '1, {$random(seed), $random(seed)});
            tick();
            set_read(WP_TILE, i % WORDS);
            tick();
        end
        wait_drain();
    endtask

    task automatic run_cfg_regs();
        for (int t = 0; t < NUM_TILES; t++) begin
            cfg_write(t, int'(CFG_REG_SCRATCH), $random(seed));
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            cfg_read(t, int'(CFG_REG_SCRATCH));
            cfg_read(t, 7);
        end
        // tile ids with no tile behind them.
        cfg_read(NUM_TILES + 1, int'(CFG_REG_SCRATCH));
        cfg_read(15, int'(CFG_REG_SCRATCH));
        wait_drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response checkers sampled mid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        expect_t e;
        if (proc_rd_data_valid === 1'b1) begin
            if (rd_q.size() == 0) begin
                abort_run("processor read response arrived with no read outstanding");
            end else begin
                e = rd_q.pop_front();
                check_value("proc_rd_data", proc_rd_data, e.data);
                check_value("proc_rd_latency", 64'(cycle - e.cycle), 64'(LATENCY));
            end
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (cfg_rsp.rd_data_valid === 1'b1) begin
            if (cfg_q.size() == 0) begin
                abort_run("config read response arrived with no config read outstanding");
            end else begin
                e = cfg_q.pop_front();
                check_value("cfg_rsp.rd_data", 64'(cfg_rsp.rd_data), e.data);
                check_value("cfg_rd_latency", 64'(cycle - e.cycle), 64'(LATENCY));
            end
        end
    end

    // watchdog.
    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout, the run did not finish within %0d cycles",
                            TOTAL_REQS + 200));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        proc_wr_en = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en = 1'b0;
        proc_rd_addr = '0;
        cfg_req = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            ref_wprot[t] = 1'b0;
            ref_scratch[t] = '0;
        end
        @(negedge rst);
        run_idle_check();
        run_full_writes();
        run_partial_strobes();
        run_read_burst();
        run_write_protect();
        run_cfg_regs();
        if (rd_q.size() != 0 || cfg_q.size() != 0) begin
            abort_run("responses still outstanding at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* all.f */
global_buffer_pkg.sv
glb_bank.sv
glb_start.sv
glb_tile.sv
global_buffer.sv
tb_clk_gen.sv
tb_global_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Builds the global buffer testbench with Verilator and runs it.
# The exit status is nonzero when the build or any check fails.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_global_buffer \
    -f all.f \
    -o tb_global_buffer_sim \
    && ./obj_dir/tb_global_buffer_sim \
    || { echo "simulation failed"; exit 1; }
